// File: Bender.yml
package:
  name: opm_reg

sources:
  - source/opm_bus_pkg.sv
  - source/opm_param_pkg.sv
  - source/opm_param_ring.sv
  - source/opm_bus_sync.sv
  - source/opm_loreg_file.sv
  - source/opm_hireg_decoder.sv
  - source/opm_ch_bank.sv
  - source/opm_op_bank.sv
  - source/opm_reg_top.sv
  - target: test
    files:
      - testbench/opm_reg_tb.sv

// File: list.f
source/opm_bus_pkg.sv
source/opm_param_pkg.sv
source/opm_param_ring.sv
source/opm_bus_sync.sv
source/opm_loreg_file.sv
source/opm_hireg_decoder.sv
source/opm_ch_bank.sv
source/opm_op_bank.sv
source/opm_reg_top.sv
testbench/opm_reg_tb.sv

// File: source/opm_bus_pkg.sv
`default_nettype none

package opm_bus_pkg;

    localparam int SLOT_W = 5;              // 32 operator slots

    // host write after synchronization, at most one strobe set per clock
    typedef struct packed {
        logic       addr_ld;
        logic       data_ld;
        logic [7:0] data;
    } bus_wr_t;

    // bit positions inside grp_en
    localparam int GRP_CONN     = 0;
    localparam int GRP_KC       = 1;
    localparam int GRP_KF       = 2;
    localparam int GRP_PMS_AMS  = 3;
    localparam int GRP_DT1_MUL  = 4;
    localparam int GRP_TL       = 5;
    localparam int GRP_KS_AR    = 6;
    localparam int GRP_AMEN_D1R = 7;
    localparam int GRP_DT2_D2R  = 8;
    localparam int GRP_D1L_RR   = 9;

    typedef struct packed {
        logic [9:0] grp_en;                 // one-hot
        logic [7:0] data;
    } hireg_wr_t;

    ////////////////////////////////////////////////////////////////////////////
    // low register map
    localparam logic [7:0] ADDR_NOISE     = 8'h0F;
    localparam logic [7:0] ADDR_CLKA1     = 8'h10;
    localparam logic [7:0] ADDR_CLKA2     = 8'h11;
    localparam logic [7:0] ADDR_CLKB      = 8'h12;
    localparam logic [7:0] ADDR_TIMER_CTL = 8'h14;
    localparam logic [7:0] ADDR_LFRQ      = 8'h18;
    localparam logic [7:0] ADDR_PMD_AMD   = 8'h19;
    localparam logic [7:0] ADDR_WAVE      = 8'h1B;

    // high group bases
    // channel groups decode on [7:3], operator groups on [7:5]
    localparam logic [7:0] BASE_CONN      = 8'h20;
    localparam logic [7:0] BASE_KC        = 8'h28;
    localparam logic [7:0] BASE_KF        = 8'h30;
    localparam logic [7:0] BASE_PMS_AMS   = 8'h38;
    localparam logic [7:0] BASE_DT1_MUL   = 8'h40;
    localparam logic [7:0] BASE_TL        = 8'h60;
    localparam logic [7:0] BASE_KS_AR     = 8'h80;
    localparam logic [7:0] BASE_AMEN_D1R  = 8'hA0;
    localparam logic [7:0] BASE_DT2_D2R   = 8'hC0;
    localparam logic [7:0] BASE_D1L_RR    = 8'hE0;

endpackage

`default_nettype wire

// File: source/opm_bus_sync.sv
`timescale 1ns/1ns
`default_nettype none

module opm_bus_sync #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                  i_EMUCLK,
    input  wire                  mrst_n,
    input  wire                  i_cs_n,
    input  wire                  i_wr_n,
    input  wire                  i_a0,
    input  wire  [7:0]           i_d,
    output opm_bus_pkg::bus_wr_t o_wr
);

logic                        strobe;
logic                        strobe_q;
logic                        a0_q;
logic [7:0]                  data_q;
logic [1:0]                  req_set;
logic [1:0]                  req_q;     // bit 0 address, bit 1 data
logic [SYNC_STAGES-1:0][1:0] sync_q;
logic [1:0]                  last_q;
logic [1:0]                  evt;

assign strobe  = ~(i_cs_n | i_wr_n);

// request is raised once, when the strobe is released
assign req_set = {2{strobe_q & ~strobe}} & {a0_q, ~a0_q};

// bus byte follows the pins as long as the strobe is low
always_ff @(posedge i_EMUCLK) begin
    if (strobe) begin
        data_q <= i_d;
        a0_q   <= i_a0;
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        strobe_q <= 1'b0;
        req_q    <= '0;
        sync_q   <= '0;
        last_q   <= '0;
    end else begin
        strobe_q <= strobe;
        req_q    <= req_set | (req_q & ~sync_q[1]);   // second stage acks the flag
        sync_q   <= {sync_q[SYNC_STAGES-2:0], req_q};
        last_q   <= sync_q[SYNC_STAGES-1];
    end
end

// rising edge of the last stage, one clock per write
assign evt  = sync_q[SYNC_STAGES-1] & ~last_q;
assign o_wr = '{addr_ld: evt[0], data_ld: evt[1], data: data_q};

endmodule

`default_nettype wire

// File: source/opm_ch_bank.sv
`timescale 1ns/1ns
`default_nettype none

module opm_ch_bank (
    input  wire                         i_EMUCLK,
    input  wire                         mrst_n,
    input  wire opm_bus_pkg::hireg_wr_t i_hwr,
    output opm_param_pkg::ch_params_t   o_ch
);

localparam int RING_LEN = 8;           // one entry per channel

opm_param_pkg::conn_t    conn_q;
opm_param_pkg::kc_t      kc_q;
opm_param_pkg::kf_t      kf_q;
opm_param_pkg::pms_ams_t pms_ams_q;

// grp_en arrives one slot after the match, rings read one stage early
// so the output lines up with o_slot again

opm_param_ring #(.T(opm_param_pkg::conn_t), .LENGTH(RING_LEN)) u_conn_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_CONN]),
    .i_d      (opm_param_pkg::conn_t'(i_hwr.data)),              // rl fl alg
    .o_q      (conn_q)
);

opm_param_ring #(.T(opm_param_pkg::kc_t), .LENGTH(RING_LEN)) u_kc_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_KC]),
    .i_d      (opm_param_pkg::kc_t'(i_hwr.data[6:0])),
    .o_q      (kc_q)
);

opm_param_ring #(.T(opm_param_pkg::kf_t), .LENGTH(RING_LEN)) u_kf_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_KF]),
    .i_d      (opm_param_pkg::kf_t'(i_hwr.data[7:2])),
    .o_q      (kf_q)
);

opm_param_ring #(.T(opm_param_pkg::pms_ams_t), .LENGTH(RING_LEN)) u_pms_ams_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_PMS_AMS]),
    .i_d      (opm_param_pkg::pms_ams_t'({i_hwr.data[6:4], i_hwr.data[1:0]})),
    .o_q      (pms_ams_q)
);

assign o_ch = '{conn: conn_q, kc: kc_q, kf: kf_q, pms_ams: pms_ams_q};

endmodule

`default_nettype wire

// File: source/opm_hireg_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module opm_hireg_decoder (
    input  wire                            i_EMUCLK,
    input  wire                            mrst_n,
    input  wire opm_bus_pkg::bus_wr_t      i_wr,
    output opm_bus_pkg::hireg_wr_t         o_hwr,
    output logic [opm_bus_pkg::SLOT_W-1:0] o_slot
);

logic [7:0]                     addr_q;
logic [7:0]                     data_q;
logic                           addr_vld_q;
logic                           data_vld_q;
logic [opm_bus_pkg::SLOT_W-1:0] slot_q;
logic                           addr_is_hi;
logic                           ch_match;
logic                           op_match;
logic [9:0]                     grp_hit;
logic [9:0]                     grp_en_q;

assign addr_is_hi = i_wr.data[7:5] != 3'b000;

// held address and data bytes
always_ff @(posedge i_EMUCLK) begin
    if (i_wr.addr_ld && addr_is_hi) begin
        addr_q <= i_wr.data;
    end
    if (i_wr.data_ld && addr_vld_q) begin
        data_q <= i_wr.data;
    end
end

////////////////////////////////////////////////////////////////////////////
// valid flags and slot counter
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        addr_vld_q <= 1'b0;
        data_vld_q <= 1'b0;
        slot_q     <= '0;
        grp_en_q   <= '0;
    end else begin
        slot_q <= slot_q + 1'b1;            // wraps 31 -> 0
        if (i_wr.addr_ld) begin
            addr_vld_q <= addr_is_hi;
            data_vld_q <= 1'b0;
        end else if (i_wr.data_ld && addr_vld_q) begin
            data_vld_q <= 1'b1;
        end
        grp_en_q <= grp_hit & {10{data_vld_q}};
    end
end

////////////////////////////////////////////////////////////////////////////
// group decode against the rotating slot
assign ch_match = addr_q[2:0] == slot_q[2:0];   // 8 channels
assign op_match = addr_q[4:0] == slot_q;        // 32 operators

assign grp_hit[opm_bus_pkg::GRP_CONN] =
    ch_match & (addr_q[7:3] == opm_bus_pkg::BASE_CONN[7:3]);
assign grp_hit[opm_bus_pkg::GRP_KC] =
    ch_match & (addr_q[7:3] == opm_bus_pkg::BASE_KC[7:3]);
assign grp_hit[opm_bus_pkg::GRP_KF] =
    ch_match & (addr_q[7:3] == opm_bus_pkg::BASE_KF[7:3]);
assign grp_hit[opm_bus_pkg::GRP_PMS_AMS] =
    ch_match & (addr_q[7:3] == opm_bus_pkg::BASE_PMS_AMS[7:3]);
assign grp_hit[opm_bus_pkg::GRP_DT1_MUL] =
    op_match & (addr_q[7:5] == opm_bus_pkg::BASE_DT1_MUL[7:5]);
assign grp_hit[opm_bus_pkg::GRP_TL] =
    op_match & (addr_q[7:5] == opm_bus_pkg::BASE_TL[7:5]);
assign grp_hit[opm_bus_pkg::GRP_KS_AR] =
    op_match & (addr_q[7:5] == opm_bus_pkg::BASE_KS_AR[7:5]);
assign grp_hit[opm_bus_pkg::GRP_AMEN_D1R] =
    op_match & (addr_q[7:5] == opm_bus_pkg::BASE_AMEN_D1R[7:5]);
assign grp_hit[opm_bus_pkg::GRP_DT2_D2R] =
    op_match & (addr_q[7:5] == opm_bus_pkg::BASE_DT2_D2R[7:5]);
assign grp_hit[opm_bus_pkg::GRP_D1L_RR] =
    op_match & (addr_q[7:5] == opm_bus_pkg::BASE_D1L_RR[7:5]);

assign o_hwr  = '{grp_en: grp_en_q, data: data_q};
assign o_slot = slot_q;

endmodule

`default_nettype wire

// File: source/opm_loreg_file.sv
`timescale 1ns/1ns
`default_nettype none

module opm_loreg_file (
    input  wire                       i_EMUCLK,
    input  wire                       mrst_n,
    input  wire opm_bus_pkg::bus_wr_t i_wr,
    output opm_param_pkg::timer_cfg_t o_timer,
    output logic                      o_timer_a_frst,
    output logic                      o_timer_b_frst,
    output opm_param_pkg::lfo_cfg_t   o_lfo,
    output logic                      o_lfrq_update
);

logic [7:0] wr_data;
logic [7:0] sel_q;          // selected low address
logic       sel_vld_q;
logic       known;
logic       wr_en;

assign wr_data = i_wr.data;

assign known = wr_data inside {opm_bus_pkg::ADDR_NOISE, opm_bus_pkg::ADDR_CLKA1,
                               opm_bus_pkg::ADDR_CLKA2, opm_bus_pkg::ADDR_CLKB,
                               opm_bus_pkg::ADDR_TIMER_CTL, opm_bus_pkg::ADDR_LFRQ,
                               opm_bus_pkg::ADDR_PMD_AMD, opm_bus_pkg::ADDR_WAVE};

assign wr_en = i_wr.data_ld & sel_vld_q;

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        sel_q          <= '0;
        sel_vld_q      <= 1'b0;
        o_timer        <= '0;
        o_lfo          <= '0;
        o_timer_a_frst <= 1'b0;
        o_timer_b_frst <= 1'b0;
        o_lfrq_update  <= 1'b0;
    end else begin
        o_timer_a_frst <= 1'b0;
        o_timer_b_frst <= 1'b0;
        o_lfrq_update  <= 1'b0;

        // high addresses and unused low ones drop the selection
        if (i_wr.addr_ld) begin
            sel_q     <= wr_data;
            sel_vld_q <= known;
        end

        if (wr_en) begin
            case (sel_q)
                opm_bus_pkg::ADDR_CLKA1: o_timer.clka[9:2] <= wr_data;
                opm_bus_pkg::ADDR_CLKA2: o_timer.clka[1:0] <= wr_data[1:0];
                opm_bus_pkg::ADDR_CLKB:  o_timer.clkb      <= wr_data;
                opm_bus_pkg::ADDR_TIMER_CTL: begin
                    {o_timer.irq_en_b, o_timer.irq_en_a,
                     o_timer.run_b, o_timer.run_a} <= wr_data[3:0];
                    o_timer_a_frst <= wr_data[4];   // flag resets
                    o_timer_b_frst <= wr_data[5];
                end
                opm_bus_pkg::ADDR_NOISE: begin
                    o_lfo.ne   <= wr_data[7];
                    o_lfo.nfrq <= wr_data[4:0];
                end
                opm_bus_pkg::ADDR_LFRQ: begin
                    o_lfo.lfrq    <= wr_data;
                    o_lfrq_update <= 1'b1;
                end
                opm_bus_pkg::ADDR_PMD_AMD: begin
                    if (wr_data[7]) begin
                        o_lfo.pmd <= wr_data[6:0];
                    end else begin
                        o_lfo.amd <= wr_data[6:0];
                    end
                end
                opm_bus_pkg::ADDR_WAVE:  o_lfo.w <= wr_data[1:0];
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

// File: source/opm_op_bank.sv
`timescale 1ns/1ns
`default_nettype none

module opm_op_bank (
    input  wire                         i_EMUCLK,
    input  wire                         mrst_n,
    input  wire opm_bus_pkg::hireg_wr_t i_hwr,
    output opm_param_pkg::op_params_t   o_op
);

localparam int RING_LEN = 32;          // one entry per operator slot

opm_param_pkg::dt1_mul_t  dt1_mul_q;
opm_param_pkg::tl_t       tl_q;
opm_param_pkg::ks_ar_t    ks_ar_q;
opm_param_pkg::amen_d1r_t amen_d1r_q;
opm_param_pkg::dt2_d2r_t  dt2_d2r_q;
opm_param_pkg::d1l_rr_t   d1l_rr_q;

opm_param_ring #(.T(opm_param_pkg::dt1_mul_t), .LENGTH(RING_LEN)) u_dt1_mul_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_DT1_MUL]),
    .i_d      (opm_param_pkg::dt1_mul_t'(i_hwr.data[6:0])),
    .o_q      (dt1_mul_q)
);

opm_param_ring #(.T(opm_param_pkg::tl_t), .LENGTH(RING_LEN)) u_tl_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_TL]),
    .i_d      (opm_param_pkg::tl_t'(i_hwr.data[6:0])),
    .o_q      (tl_q)
);

opm_param_ring #(.T(opm_param_pkg::ks_ar_t), .LENGTH(RING_LEN)) u_ks_ar_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_KS_AR]),
    .i_d      (opm_param_pkg::ks_ar_t'({i_hwr.data[7:6], i_hwr.data[4:0]})),
    .o_q      (ks_ar_q)
);

opm_param_ring #(.T(opm_param_pkg::amen_d1r_t), .LENGTH(RING_LEN)) u_amen_d1r_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_AMEN_D1R]),
    .i_d      (opm_param_pkg::amen_d1r_t'({i_hwr.data[7], i_hwr.data[4:0]})),
    .o_q      (amen_d1r_q)
);

opm_param_ring #(.T(opm_param_pkg::dt2_d2r_t), .LENGTH(RING_LEN)) u_dt2_d2r_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_DT2_D2R]),
    .i_d      (opm_param_pkg::dt2_d2r_t'({i_hwr.data[7:6], i_hwr.data[4:0]})),
    .o_q      (dt2_d2r_q)
);

opm_param_ring #(.T(opm_param_pkg::d1l_rr_t), .LENGTH(RING_LEN)) u_d1l_rr_ring (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_load   (i_hwr.grp_en[opm_bus_pkg::GRP_D1L_RR]),
    .i_d      (opm_param_pkg::d1l_rr_t'(i_hwr.data)),
    .o_q      (d1l_rr_q)
);

assign o_op = '{dt1_mul:  dt1_mul_q,
                tl:       tl_q,
                ks_ar:    ks_ar_q,
                amen_d1r: amen_d1r_q,
                dt2_d2r:  dt2_d2r_q,
                d1l_rr:   d1l_rr_q};

endmodule

`default_nettype wire

// File: source/opm_param_pkg.sv
`default_nettype none

package opm_param_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // low registers
    typedef struct packed {
        logic [9:0] clka;       // 0x10 holds [9:2], 0x11 holds [1:0]
        logic [7:0] clkb;
        logic       run_a;
        logic       run_b;
        logic       irq_en_a;
        logic       irq_en_b;
    } timer_cfg_t;

    typedef struct packed {
        logic [7:0] lfrq;
        logic [6:0] pmd;
        logic [6:0] amd;
        logic [1:0] w;          // lfo waveform
        logic       ne;         // noise enable
        logic [4:0] nfrq;
    } lfo_cfg_t;

    ////////////////////////////////////////////////////////////////////////////
    // per-channel payloads, 0x20-0x3F
    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fl;         // feedback level
        logic [2:0] alg;
    } conn_t;

    typedef struct packed {
        logic [6:0] kc;
    } kc_t;

    typedef struct packed {
        logic [5:0] kf;
    } kf_t;

    typedef struct packed {
        logic [2:0] pms;
        logic [1:0] ams;        // raw, amen gating is downstream
    } pms_ams_t;

    typedef struct packed {
        conn_t    conn;
        kc_t      kc;
        kf_t      kf;
        pms_ams_t pms_ams;
    } ch_params_t;

    ////////////////////////////////////////////////////////////////////////////
    // per-operator payloads, 0x40-0xFF
    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
    } dt1_mul_t;

    typedef struct packed {
        logic [6:0] tl;
    } tl_t;

    typedef struct packed {
        logic [1:0] ks;
        logic [4:0] ar;
    } ks_ar_t;

    typedef struct packed {
        logic       amen;
        logic [4:0] d1r;
    } amen_d1r_t;

    typedef struct packed {
        logic [1:0] dt2;
        logic [4:0] d2r;
    } dt2_d2r_t;

    typedef struct packed {
        logic [3:0] d1l;
        logic [3:0] rr;
    } d1l_rr_t;

    typedef struct packed {
        dt1_mul_t  dt1_mul;
        tl_t       tl;
        ks_ar_t    ks_ar;
        amen_d1r_t amen_d1r;
        dt2_d2r_t  dt2_d2r;
        d1l_rr_t   d1l_rr;
    } op_params_t;

endpackage

`default_nettype wire

// File: source/opm_param_ring.sv
`timescale 1ns/1ns
`default_nettype none

module opm_param_ring #(
    parameter type T      = logic [7:0],
    parameter int  LENGTH = 8
) (
    input  wire   i_EMUCLK,
    input  wire   mrst_n,
    input  wire   i_load,
    input  wire T i_d,
    output T      o_q
);

T [LENGTH-1:0] stage_q;
T              head;

// load point sits between tail and head
assign head = i_load ? i_d : stage_q[LENGTH-1];

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        stage_q <= '0;
    end else begin
        stage_q <= {stage_q[LENGTH-2:0], head};
    end
end

// entry due at the load point on the next clock
assign o_q = stage_q[LENGTH-2];

endmodule

`default_nettype wire

// File: source/opm_reg_top.sv
`timescale 1ns/1ns
`default_nettype none

module opm_reg_top #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                            i_EMUCLK,
    input  wire                            mrst_n,
    input  wire                            i_cs_n,
    input  wire                            i_wr_n,
    input  wire                            i_a0,
    input  wire  [7:0]                     i_d,
    output opm_param_pkg::timer_cfg_t      o_timer,
    output logic                           o_timer_a_frst,
    output logic                           o_timer_b_frst,
    output opm_param_pkg::lfo_cfg_t        o_lfo,
    output logic                           o_lfrq_update,
    output logic [opm_bus_pkg::SLOT_W-1:0] o_slot,
    output opm_param_pkg::ch_params_t      o_ch,
    output opm_param_pkg::op_params_t      o_op
);

opm_bus_pkg::bus_wr_t   bus_wr;
opm_bus_pkg::hireg_wr_t hireg_wr;

////////////////////////////////////////////////////////////////////////////
// host port
opm_bus_sync #(.SYNC_STAGES(SYNC_STAGES)) u_bus_sync (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_cs_n   (i_cs_n),
    .i_wr_n   (i_wr_n),
    .i_a0     (i_a0),
    .i_d      (i_d),
    .o_wr     (bus_wr)
);

////////////////////////////////////////////////////////////////////////////
// decoders
opm_loreg_file u_loreg (
    .i_EMUCLK       (i_EMUCLK),
    .mrst_n         (mrst_n),
    .i_wr           (bus_wr),
    .o_timer        (o_timer),
    .o_timer_a_frst (o_timer_a_frst),
    .o_timer_b_frst (o_timer_b_frst),
    .o_lfo          (o_lfo),
    .o_lfrq_update  (o_lfrq_update)
);

opm_hireg_decoder u_hireg (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_wr     (bus_wr),
    .o_hwr    (hireg_wr),
    .o_slot   (o_slot)
);

////////////////////////////////////////////////////////////////////////////
// parameter storage
opm_ch_bank u_ch_bank (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_hwr    (hireg_wr),
    .o_ch     (o_ch)
);

opm_op_bank u_op_bank (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_hwr    (hireg_wr),
    .o_op     (o_op)
);

endmodule

`default_nettype wire

// File: testbench/opm_reg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module opm_reg_tb;

logic                      i_EMUCLK;
logic                      mrst_n;
logic                      i_cs_n;
logic                      i_wr_n;
logic                      i_a0;
logic [7:0]                i_d;
opm_param_pkg::timer_cfg_t o_timer;
logic                      o_timer_a_frst;
logic                      o_timer_b_frst;
opm_param_pkg::lfo_cfg_t   o_lfo;
logic                      o_lfrq_update;
logic [4:0]                o_slot;
opm_param_pkg::ch_params_t o_ch;
opm_param_pkg::op_params_t o_op;

// reference model of the register contents
opm_param_pkg::timer_cfg_t timer_exp;
opm_param_pkg::lfo_cfg_t   lfo_exp;
opm_param_pkg::ch_params_t ch_exp [8];
opm_param_pkg::op_params_t op_exp [32];
logic [7:0]                cur_addr;
logic [31:0]               lfsr_q;
int                        errors;
int                        test_base;
int                        tests_run;
int                        tests_ok;
int                        lfrq_cnt;
int                        frst_a_cnt;
int                        frst_b_cnt;

opm_reg_top #(.SYNC_STAGES(3)) UUT (.*);

always #50 i_EMUCLK = ~i_EMUCLK;

// pulse counters sample on the falling edge
always @(negedge i_EMUCLK) begin
    if (o_lfrq_update)  lfrq_cnt++;
    if (o_timer_a_frst) frst_a_cnt++;
    if (o_timer_b_frst) frst_b_cnt++;
end

////////////////////////////////////////////////////////////////////////////
// helpers
task automatic tick();
    @(posedge i_EMUCLK);
    #5;                                 // drive and sample point
endtask

task automatic idle(input int n);
    repeat (n) tick();
endtask

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
endfunction

task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    repeat (n) begin
        lfsr_q = lfsr_step(lfsr_q);
        v      = {v[6:0], lfsr_q[0]};
    end
endtask

task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
        $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic wait_slot(input logic [4:0] n, input logic [4:0] mask);
    bit found;
    found = 1'b0;
    for (int k = 0; k < 64 && !found; k++) begin
        if ((o_slot & mask) == n) begin
            found = 1'b1;
        end else begin
            tick();
        end
    end
    assert (found) else begin
        $display("%0t ns: o_slot never reached %0d within 64 clocks", $time, n);
        errors++;
    end
endtask

// register layout applied to the model
task automatic model_apply(input logic [7:0] d);
    if (cur_addr[7:5] == 3'b000) begin
        case (cur_addr)
            8'h0F: {lfo_exp.ne, lfo_exp.nfrq} = {d[7], d[4:0]};
            8'h10: timer_exp.clka[9:2] = d;
            8'h11: timer_exp.clka[1:0] = d[1:0];
            8'h12: timer_exp.clkb = d;
            8'h14: begin
                timer_exp.run_a    = d[0];
                timer_exp.run_b    = d[1];
                timer_exp.irq_en_a = d[2];
                timer_exp.irq_en_b = d[3];
            end
            8'h18: lfo_exp.lfrq = d;
            8'h19: begin
                if (d[7]) begin
                    lfo_exp.pmd = d[6:0];
                end else begin
                    lfo_exp.amd = d[6:0];
                end
            end
            8'h1B: lfo_exp.w = d[1:0];
            default: ;
        endcase
    end else if (cur_addr < 8'h40) begin
        case (cur_addr[4:3])
            2'd0: ch_exp[cur_addr[2:0]].conn = '{rl: d[7:6], fl: d[5:3], alg: d[2:0]};
            2'd1: ch_exp[cur_addr[2:0]].kc.kc = d[6:0];
            2'd2: ch_exp[cur_addr[2:0]].kf.kf = d[7:2];
            2'd3: ch_exp[cur_addr[2:0]].pms_ams = '{pms: d[6:4], ams: d[1:0]};
        endcase
    end else begin
        case (cur_addr[7:5])
            3'd2: op_exp[cur_addr[4:0]].dt1_mul = '{dt1: d[6:4], mul: d[3:0]};
            3'd3: op_exp[cur_addr[4:0]].tl.tl = d[6:0];
            3'd4: op_exp[cur_addr[4:0]].ks_ar = '{ks: d[7:6], ar: d[4:0]};
            3'd5: op_exp[cur_addr[4:0]].amen_d1r = '{amen: d[7], d1r: d[4:0]};
            3'd6: op_exp[cur_addr[4:0]].dt2_d2r = '{dt2: d[7:6], d2r: d[4:0]};
            default: op_exp[cur_addr[4:0]].d1l_rr = '{d1l: d[7:4], rr: d[3:0]};
        endcase
    end
endtask

////////////////////////////////////////////////////////////////////////////
// host bus
task automatic write_bus(input logic a0, input logic [7:0] d);
    i_a0   = a0;
    i_d    = d;
    i_cs_n = 1'b0;
    i_wr_n = 1'b0;
    idle(2);                            // minimum strobe width
    i_cs_n = 1'b1;
    i_wr_n = 1'b1;
endtask

task automatic write_addr(input logic [7:0] a);
    cur_addr = a;
    write_bus(1'b0, a);
    idle(12);
endtask

task automatic write_data(input logic [7:0] d);
    model_apply(d);
    write_bus(1'b1, d);
    idle(cur_addr[7:5] != 3'b000 ? 40 : 12);
endtask

task automatic low_write(input logic [7:0] a, input logic [7:0] d);
    int exp_a;
    int exp_b;
    int exp_u;
    exp_a      = (a == 8'h14) ? d[4] : 0;
    exp_b      = (a == 8'h14) ? d[5] : 0;
    exp_u      = (a == 8'h18) ? 1 : 0;
    lfrq_cnt   = 0;
    frst_a_cnt = 0;
    frst_b_cnt = 0;
    write_addr(a);
    write_data(d);
    check_eq("o_timer", o_timer, timer_exp);
    check_eq("o_lfo", o_lfo, lfo_exp);
    check_eq("o_lfrq_update pulses", lfrq_cnt, exp_u);
    check_eq("o_timer_a_frst pulses", frst_a_cnt, exp_a);
    check_eq("o_timer_b_frst pulses", frst_b_cnt, exp_b);
endtask

// one full rotation against the model
task automatic scan_banks();
    repeat (32) begin
        tick();
        check_eq("o_ch", o_ch, ch_exp[o_slot[2:0]]);
        check_eq("o_op", o_op, op_exp[o_slot]);
    end
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_base) begin
        tests_ok++;
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
endtask

////////////////////////////////////////////////////////////////////////////
// stimulus
initial begin
    logic [7:0] r;
    logic [4:0] nxt;
    logic [2:0] ch;
    logic [4:0] sl;

    i_EMUCLK = 1'b0;
    mrst_n   = 1'b0;
    i_cs_n   = 1'b1;
    i_wr_n   = 1'b1;
    i_a0     = 1'b0;
    i_d      = '0;
    lfsr_q   = 32'd32;
    cur_addr = '0;
    timer_exp = '0;
    lfo_exp   = '0;
    foreach (ch_exp[k]) ch_exp[k] = '0;
    foreach (op_exp[k]) op_exp[k] = '0;
    errors = 0;
    test_base = 0;
    tests_run = 0;
    tests_ok = 0;
    lfrq_cnt = 0;
    frst_a_cnt = 0;
    frst_b_cnt = 0;

    repeat (4) @(posedge i_EMUCLK);
    #5 mrst_n = 1'b1;

    // reset state and slot counter
    check_eq("o_slot", o_slot, 5'd0);
    check_eq("o_timer", o_timer, '0);
    check_eq("o_lfo", o_lfo, '0);
    nxt = 5'd0;
    repeat (40) begin
        nxt = nxt + 5'd1;               // wraps after 31
        tick();
        check_eq("o_slot", o_slot, nxt);
    end
    scan_banks();
    check_eq("pulse count after reset", lfrq_cnt + frst_a_cnt + frst_b_cnt, 0);
    finish_test("reset state");

    // low registers
    draw_bits(8, r);
    low_write(8'h10, r);
    draw_bits(8, r);
    low_write(8'h11, r);
    draw_bits(8, r);
    low_write(8'h12, r);
    draw_bits(8, r);
    low_write(8'h0F, r);
    draw_bits(8, r);
    low_write(8'h18, r);
    draw_bits(8, r);
    low_write(8'h1B, r);
    draw_bits(8, r);
    low_write(8'h19, r | 8'h80);        // pmd only
    draw_bits(8, r);
    low_write(8'h19, r & 8'h7F);        // amd only
    finish_test("low registers");

    // timer control with both flag resets, neither, then one at a time
    draw_bits(8, r);
    low_write(8'h14, r | 8'h30);
    draw_bits(8, r);
    low_write(8'h14, r & 8'hCF);
    draw_bits(8, r);
    low_write(8'h14, (r & 8'hCF) | 8'h10);
    draw_bits(8, r);
    low_write(8'h14, (r & 8'hCF) | 8'h20);
    finish_test("timer control");

    // all four channel groups of one channel
    draw_bits(3, r);
    ch = r[2:0];
    for (int g = 0; g < 4; g++) begin
        write_addr(8'h20 | (g << 3) | ch);
        draw_bits(8, r);
        write_data(r);
    end
    wait_slot({2'b00, ch}, 5'h07);
    check_eq("o_ch", o_ch, ch_exp[ch]);
    scan_banks();
    finish_test("channel registers");

    // two operator groups on one slot
    draw_bits(5, r);
    sl = r[4:0];
    write_addr(8'h80 | sl);
    draw_bits(8, r);
    write_data(r);
    write_addr(8'hA0 | sl);
    draw_bits(8, r);
    write_data(r);
    wait_slot(sl, 5'h1F);
    check_eq("o_op.ks_ar", o_op.ks_ar, op_exp[sl].ks_ar);
    check_eq("o_op.amen_d1r", o_op.amen_d1r, op_exp[sl].amen_d1r);
    scan_banks();
    finish_test("operator registers");

    // a low address drops the pending high one
    write_addr(8'h28 | ch);
    draw_bits(8, r);
    low_write(8'h18, r);
    scan_banks();
    finish_test("address override");

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_ok, tests_run - tests_ok, errors);
    if (errors == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire
